// File: common/simd_alu_macros.svh
`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

// Full operand width
`define SIMD_ALU_DATA_W 64

// Width of one lane ALU
`define SIMD_ALU_LANE_W 8

// Number of lane ALUs in the carry chain
`define SIMD_ALU_LANES 8

// Cycles from input strobe to output strobe
`define SIMD_ALU_LATENCY 3

`endif

// File: common/simd_alu_pkg.sv
`include "simd_alu_macros.svh"

package simd_alu_pkg;

	typedef enum logic [3:0]
	{
		op_add,
		op_sub,
		op_slt,
		op_and,
		op_orr,
		op_xor,
		op_inv,
		op_not,
		op_asr
	} op_e;

	// Element size, also log2 of the lanes per element
	typedef enum logic [1:0]
	{
		sz_8,
		sz_16,
		sz_32,
		sz_64
	} size_e;

	// Lane logic function
	typedef enum logic [1:0]
	{
		lg_and,
		lg_orr,
		lg_xor,
		lg_inv
	} logic_e;

	typedef struct packed
	{
		logic [`SIMD_ALU_DATA_W-1:0] a;
		logic [`SIMD_ALU_DATA_W-1:0] b;
		op_e op;
		size_e size;
	} alu_req_t;

	typedef struct packed
	{
		logic [`SIMD_ALU_DATA_W-1:0] a;
		logic [`SIMD_ALU_DATA_W-1:0] b;
		size_e size;
		logic invert_b;
		logic carry_seed;
		logic arith;
		logic_e logic_sel;
		logic use_shift;
		logic is_slt;
		logic is_not;
	} exec_ctl_t;

	// For not, lane_slt holds the element zero test at each top lane
	typedef struct packed
	{
		logic [`SIMD_ALU_DATA_W-1:0] data;
		logic [`SIMD_ALU_LANES-1:0] lane_carry;
		logic [`SIMD_ALU_LANES-1:0] lane_slt;
		size_e size;
		logic is_slt;
		logic is_not;
	} exec_res_t;

	typedef struct packed
	{
		logic [`SIMD_ALU_DATA_W-1:0] data;
		logic [`SIMD_ALU_LANES-1:0] carry_mask;
	} alu_rsp_t;

endpackage

// File: source/simd_stage_reg.sv
`timescale 1ns/1ps

module simd_stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
		end
	end

	// Payload only moves with a valid operation
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			out_data <= in_data;
		end
	end

endmodule

// File: source/simd_alu_decode.sv
`timescale 1ns/1ps

module simd_alu_decode (
	input simd_alu_pkg::alu_req_t req,
	output simd_alu_pkg::exec_ctl_t ctl
);

	always_comb
	begin
		ctl.a = req.a;
		ctl.b = req.b;
		ctl.size = req.size;
		ctl.invert_b = 1'b0;
		ctl.carry_seed = 1'b0;
		ctl.arith = 1'b0;
		ctl.logic_sel = simd_alu_pkg::lg_and;
		ctl.use_shift = 1'b0;
		ctl.is_slt = 1'b0;
		ctl.is_not = 1'b0;

		case (req.op)
		simd_alu_pkg::op_add:
		begin
			ctl.arith = 1'b1;
		end

		// a + ~b + 1 at every element start
		simd_alu_pkg::op_sub,
		simd_alu_pkg::op_slt:
		begin
			ctl.arith = 1'b1;
			ctl.invert_b = 1'b1;
			ctl.carry_seed = 1'b1;
			ctl.is_slt = (req.op == simd_alu_pkg::op_slt);
		end

		simd_alu_pkg::op_orr: ctl.logic_sel = simd_alu_pkg::lg_orr;
		simd_alu_pkg::op_xor: ctl.logic_sel = simd_alu_pkg::lg_xor;
		simd_alu_pkg::op_inv: ctl.logic_sel = simd_alu_pkg::lg_inv;
		simd_alu_pkg::op_not: ctl.is_not = 1'b1;
		simd_alu_pkg::op_asr: ctl.use_shift = 1'b1;

		// And, plus unused codes
		default:
		begin
			ctl.logic_sel = simd_alu_pkg::lg_and;
		end
		endcase
	end

endmodule

// File: simd_lane_alu/simd_lane_alu.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_lane_alu #(
	parameter int unsigned LANE_INDEX = 0
) (
	input logic [`SIMD_ALU_LANE_W-1:0] a,
	input logic [`SIMD_ALU_LANE_W-1:0] b,
	input simd_alu_pkg::size_e size,
	input logic carry_seed,
	input logic carry_chain,
	input simd_alu_pkg::exec_ctl_t ctl,
	output logic [`SIMD_ALU_LANE_W-1:0] data,
	output logic carry,
	output logic slt
);

	localparam int MSB = `SIMD_ALU_LANE_W - 1;

	logic elem_start;
	logic carry_in;
	logic [`SIMD_ALU_LANE_W-1:0] b_eff;

	// Does this lane hold the lowest byte of its element
	always_comb
	begin
		case (size)
		simd_alu_pkg::sz_8:
		begin
			elem_start = 1'b1;
		end
		simd_alu_pkg::sz_16:
		begin
			elem_start = ((LANE_INDEX % 2) == 0);
		end
		simd_alu_pkg::sz_32:
		begin
			elem_start = ((LANE_INDEX % 4) == 0);
		end
		default:
		begin
			elem_start = (LANE_INDEX == 0);
		end
		endcase
	end

	assign carry_in = elem_start ? carry_seed : carry_chain;
	assign b_eff = ctl.invert_b ? ~b : b;

	always_comb
	begin
		if (ctl.arith)
		begin
			{carry, data} = {1'b0, a} + {1'b0, b_eff}
				+ {{`SIMD_ALU_LANE_W{1'b0}}, carry_in};
		end
		else
		begin
			carry = 1'b0;
			case (ctl.logic_sel)
			simd_alu_pkg::lg_and: data = a & b;
			simd_alu_pkg::lg_orr: data = a | b;
			simd_alu_pkg::lg_xor: data = a ^ b;
			default: data = ~a;
			endcase
		end
	end

	// With differing signs a is less exactly when negative
	// With equal signs the difference sign decides
	assign slt = (a[MSB] != b[MSB]) ? a[MSB] : data[MSB];

endmodule

// File: source/simd_shift_unit.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_shift_unit (
	input logic [`SIMD_ALU_DATA_W-1:0] a,
	input logic [`SIMD_ALU_DATA_W-1:0] b,
	input simd_alu_pkg::size_e size,
	output logic [`SIMD_ALU_DATA_W-1:0] data
);

	// One result per element size, picked at the end
	logic [`SIMD_ALU_DATA_W-1:0] shifted [4];

	for (genvar s = 0; s < 4; s++)
	begin : g_size
		localparam int W = `SIMD_ALU_LANE_W << s;

		for (genvar e = 0; e < `SIMD_ALU_DATA_W / W; e++)
		begin : g_elem
			logic [W-1:0] elem;
			logic [W-1:0] amount;

			assign elem = a[e*W +: W];
			assign amount = b[e*W +: W];

			// Full width or more leaves only sign bits
			assign shifted[s][e*W +: W] = (amount >= W)
				? {W{elem[W-1]}}
				: W'($signed(elem) >>> amount);
		end
	end

	always_comb
	begin
		case (size)
		simd_alu_pkg::sz_8:
		begin
			data = shifted[0];
		end
		simd_alu_pkg::sz_16:
		begin
			data = shifted[1];
		end
		simd_alu_pkg::sz_32:
		begin
			data = shifted[2];
		end
		default:
		begin
			data = shifted[3];
		end
		endcase
	end

endmodule

// File: source/simd_alu_execute.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_alu_execute (
	input simd_alu_pkg::exec_ctl_t ctl,
	output simd_alu_pkg::exec_res_t res
);

	localparam int LANES = `SIMD_ALU_LANES;
	localparam int LW = `SIMD_ALU_LANE_W;

	logic [`SIMD_ALU_DATA_W-1:0] lane_data;
	logic [`SIMD_ALU_DATA_W-1:0] shift_data;
	logic [LANES-1:0] lane_carry;
	logic [LANES-1:0] lane_slt;
	logic [LANES-1:0] chain_in;
	logic [LANES-1:0] lane_zero;
	logic [LANES-1:0] elem_zero;

	// Lane 0 always starts an element, so its chain input is never taken
	assign chain_in = {lane_carry[LANES-2:0], 1'b0};

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		simd_lane_alu #(
			.LANE_INDEX(i)
		) u_lane (
			.a(ctl.a[i*LW +: LW]),
			.b(ctl.b[i*LW +: LW]),
			.size(ctl.size),
			.carry_seed(ctl.carry_seed),
			.carry_chain(chain_in[i]),
			.ctl(ctl),
			.data(lane_data[i*LW +: LW]),
			.carry(lane_carry[i]),
			.slt(lane_slt[i])
		);

		assign lane_zero[i] = ~|ctl.a[i*LW +: LW];
	end

	simd_shift_unit u_shift (
		.a(ctl.a),
		.b(ctl.b),
		.size(ctl.size),
		.data(shift_data)
	);

	// Zero test of the whole element, repeated on each of its lanes
	always_comb
	begin
		int mask;
		int base;
		logic z;

		mask = (1 << ctl.size) - 1;
		for (int i = 0; i < LANES; i++)
		begin
			base = i & ~mask;
			z = 1'b1;
			for (int j = 0; j < LANES; j++)
			begin
				if (j >= base && j <= base + mask)
				begin
					z &= lane_zero[j];
				end
			end
			elem_zero[i] = z;
		end
	end

	assign res.data = ctl.use_shift ? shift_data : lane_data;
	assign res.lane_carry = lane_carry;
	assign res.lane_slt = ctl.is_not ? elem_zero : lane_slt;
	assign res.size = ctl.size;
	assign res.is_slt = ctl.is_slt;
	assign res.is_not = ctl.is_not;

endmodule

// File: source/simd_alu_result.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_alu_result (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input simd_alu_pkg::exec_res_t res,
	output logic out_valid,
	output simd_alu_pkg::alu_rsp_t rsp
);

	localparam int LANES = `SIMD_ALU_LANES;
	localparam int LW = `SIMD_ALU_LANE_W;

	simd_alu_pkg::alu_rsp_t rsp_d;

	always_comb
	begin
		int top;
		logic flag_op;

		flag_op = res.is_slt || res.is_not;
		rsp_d.data = flag_op ? '0 : res.data;
		rsp_d.carry_mask = '0;

		// Work on the lowest lane of each element, reading its top lane
		for (int i = 0; i < LANES; i++)
		begin
			top = i + (1 << res.size) - 1;
			if ((i & ((1 << res.size) - 1)) == 0)
			begin
				rsp_d.carry_mask[i] = res.lane_carry[top];
				if (flag_op)
				begin
					rsp_d.data[i*LW] = res.lane_slt[top];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			rsp <= rsp_d;
		end
	end

endmodule

// File: source/simd_alu_top.sv
`timescale 1ns/1ps

module simd_alu_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input simd_alu_pkg::alu_req_t req,
	output logic out_valid,
	output simd_alu_pkg::alu_rsp_t rsp
);

	simd_alu_pkg::exec_ctl_t ctl;
	simd_alu_pkg::exec_ctl_t ctl_q;
	simd_alu_pkg::exec_res_t res;
	simd_alu_pkg::exec_res_t res_q;
	logic ctl_valid;
	logic res_valid;

	simd_alu_decode u_decode (
		.req(req),
		.ctl(ctl)
	);

	simd_stage_reg #(
		.payload_t(simd_alu_pkg::exec_ctl_t)
	) u_ctl_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_data(ctl),
		.out_valid(ctl_valid),
		.out_data(ctl_q)
	);

	simd_alu_execute u_execute (
		.ctl(ctl_q),
		.res(res)
	);

	simd_stage_reg #(
		.payload_t(simd_alu_pkg::exec_res_t)
	) u_res_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(ctl_valid),
		.in_data(res),
		.out_valid(res_valid),
		.out_data(res_q)
	);

	simd_alu_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(res_valid),
		.res(res_q),
		.out_valid(out_valid),
		.rsp(rsp)
	);

endmodule

// File: dv/simd_alu_chk.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_alu_chk (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input simd_alu_pkg::alu_rsp_t rsp
);

	// Count of failed assertions
	int unsigned error_count = 0;

	// Output strobe stays low while reset is held
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
	else
	begin
		$error("out_valid high during reset");
		error_count++;
	end

	// Fixed pipeline depth without stalls
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, `SIMD_ALU_LATENCY))
	else
	begin
		$error("out_valid does not follow in_valid by the pipeline depth");
		error_count++;
	end

	rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(rsp))
	else
	begin
		$error("rsp has unknown bits while out_valid is high");
		error_count++;
	end

endmodule

// File: dv/simd_alu_tb.sv
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_alu_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;
	localparam int DIRECTED_OPS = 57;
	localparam int RANDOM_OPS = 200;
	localparam int MARGIN_CYCLES = 20;
	localparam int RUN_CYCLES = RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS
		+ `SIMD_ALU_LATENCY + MARGIN_CYCLES;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	simd_alu_pkg::alu_req_t req;
	logic out_valid;
	simd_alu_pkg::alu_rsp_t rsp;

	logic [31:0] lfsr_state = 32'd99;
	int cycle_count = 0;
	simd_alu_pkg::alu_rsp_t exp_q[$];
	int exp_cycle_q[$];

	simd_alu_top i_simd_alu_top (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.req(req),
		.out_valid(out_valid),
		.rsp(rsp)
	);

	bind simd_alu_top simd_alu_chk u_chk (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.rsp(rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	task automatic fail_and_stop(string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_field(string name, logic [63:0] actual, logic [63:0] expected);
		assert (actual === expected)
		else fail_and_stop($sformatf("Mismatch at time %0t: %s expected 0x%h, actual 0x%h",
			$time, name, expected, actual));
	endtask

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic out_bit;

		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit)
		begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	function automatic logic [63:0] random_bits(int n);
		logic [63:0] r;

		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[62:0], lfsr_step()};
		end
		return r;
	endfunction

	function automatic logic [63:0] elem_mask(int w);
		return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
	endfunction

	// Same value in every element
	function automatic logic [63:0] splat(simd_alu_pkg::size_e size, logic [63:0] value);
		int w;
		logic [63:0] r;

		w = 8 << size;
		r = '0;
		for (int pos = 0; pos < 64; pos += w)
		begin
			r |= (value & elem_mask(w)) << pos;
		end
		return r;
	endfunction

	// Reference model working one element at a time
	function automatic simd_alu_pkg::alu_rsp_t expected_rsp(simd_alu_pkg::alu_req_t r);
		simd_alu_pkg::alu_rsp_t e;
		int w;
		logic [63:0] mask;
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] val;
		logic [64:0] sum;
		logic cout;

		w = 8 << r.size;
		mask = elem_mask(w);
		e = '0;
		for (int pos = 0; pos < 64; pos += w)
		begin
			ea = (r.a >> pos) & mask;
			eb = (r.b >> pos) & mask;
			sa = ea[w-1] ? (ea | ~mask) : ea;
			sb = eb[w-1] ? (eb | ~mask) : eb;
			cout = 1'b0;
			case (r.op)
			simd_alu_pkg::op_add:
			begin
				sum = {1'b0, ea} + {1'b0, eb};
				val = sum[63:0];
				cout = sum[w];
			end
			simd_alu_pkg::op_sub:
			begin
				val = ea - eb;
				cout = (ea >= eb);
			end
			simd_alu_pkg::op_slt:
			begin
				val = ($signed(sa) < $signed(sb)) ? 64'd1 : 64'd0;
				cout = (ea >= eb);
			end
			simd_alu_pkg::op_orr: val = ea | eb;
			simd_alu_pkg::op_xor: val = ea ^ eb;
			simd_alu_pkg::op_inv: val = ~ea;
			simd_alu_pkg::op_not: val = (ea == 64'd0) ? 64'd1 : 64'd0;
			simd_alu_pkg::op_asr: val = (eb >= w) ? {64{sa[63]}} : 64'($signed(sa) >>> eb);
			default: val = ea & eb;
			endcase
			e.data |= (val & mask) << pos;
			e.carry_mask[pos / 8] = cout;
		end
		return e;
	endfunction

	task automatic issue_op(simd_alu_pkg::op_e op, simd_alu_pkg::size_e size,
		logic [63:0] a, logic [63:0] b);
		simd_alu_pkg::alu_req_t r;

		r.a = a;
		r.b = b;
		r.op = op;
		r.size = size;
		in_valid = 1'b1;
		req = r;
		exp_q.push_back(expected_rsp(r));
		exp_cycle_q.push_back(cycle_count + `SIMD_ALU_LATENCY);
		@(posedge clk);
		#0.5;
	endtask

	task automatic run_directed();
		simd_alu_pkg::size_e sz;
		logic [63:0] min_val;
		int w;

		for (int s = 0; s < 4; s++)
		begin
			sz = simd_alu_pkg::size_e'(s);
			w = 8 << s;
			min_val = 64'd1 << (w - 1);
			// Carries ripple through every lane of the element
			issue_op(simd_alu_pkg::op_add, sz, '1, splat(sz, 64'd1));
			issue_op(simd_alu_pkg::op_add, sz, '1, 64'd1);
			issue_op(simd_alu_pkg::op_sub, sz, '0, splat(sz, 64'd1));
			issue_op(simd_alu_pkg::op_sub, sz, '1, '1);
			issue_op(simd_alu_pkg::op_slt, sz, splat(sz, min_val), splat(sz, min_val - 1));
			issue_op(simd_alu_pkg::op_slt, sz, splat(sz, min_val - 1), splat(sz, min_val));
			issue_op(simd_alu_pkg::op_slt, sz, splat(sz, min_val), splat(sz, min_val));
			issue_op(simd_alu_pkg::op_slt, sz, splat(sz, min_val), splat(sz, 64'd1));
			issue_op(simd_alu_pkg::op_not, sz, 64'h0000_0000_00FF_0000, '0);
			// Shift by zero, width minus one, width, and far beyond
			issue_op(simd_alu_pkg::op_asr, sz, 64'h8765_4321_F0E1_5A3C, '0);
			issue_op(simd_alu_pkg::op_asr, sz, 64'h8765_4321_F0E1_5A3C, splat(sz, w - 1));
			issue_op(simd_alu_pkg::op_asr, sz, 64'h8765_4321_F0E1_5A3C, splat(sz, w));
			issue_op(simd_alu_pkg::op_asr, sz, 64'h8765_4321_F0E1_5A3C, '1);
		end
		issue_op(simd_alu_pkg::op_not, simd_alu_pkg::sz_64, '0, '0);
		issue_op(simd_alu_pkg::op_and, simd_alu_pkg::sz_8, 64'hF0F0_CC33_0000_FFFF,
			64'h0FF0_AAAA_1234_00FF);
		issue_op(simd_alu_pkg::op_orr, simd_alu_pkg::sz_8, 64'hF0F0_CC33_0000_FFFF,
			64'h0FF0_AAAA_1234_00FF);
		issue_op(simd_alu_pkg::op_xor, simd_alu_pkg::sz_8, 64'hF0F0_CC33_0000_FFFF,
			64'h0FF0_AAAA_1234_00FF);
		issue_op(simd_alu_pkg::op_inv, simd_alu_pkg::sz_8, 64'hF0F0_CC33_0000_FFFF, '0);
	endtask

	task automatic run_random();
		simd_alu_pkg::op_e op;
		simd_alu_pkg::size_e sz;
		logic [63:0] a;
		logic [63:0] b;

		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			op = simd_alu_pkg::op_e'(random_bits(4) % 9);
			sz = simd_alu_pkg::size_e'(random_bits(2));
			a = random_bits(64);
			b = random_bits(64);
			issue_op(op, sz, a, b);
		end
	endtask

	// Outputs change on the rising edge and are compared on the falling one
	always @(negedge clk)
	begin : monitor
		simd_alu_pkg::alu_rsp_t exp_rsp;
		int exp_cycle;

		assert (i_simd_alu_top.u_chk.error_count == 0)
		else fail_and_stop("A bound checker assertion failed");
		if (!rst_n)
		begin
			assert (!out_valid)
			else fail_and_stop("out_valid is high while reset is asserted");
		end
		else if (out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				fail_and_stop("out_valid is high with no operation outstanding");
			end
			else
			begin
				exp_rsp = exp_q.pop_front();
				exp_cycle = exp_cycle_q.pop_front();
				check_field("rsp.data", rsp.data, exp_rsp.data);
				check_field("rsp.carry_mask", 64'(rsp.carry_mask), 64'(exp_rsp.carry_mask));
				assert (cycle_count == exp_cycle)
				else fail_and_stop($sformatf("Result arrived in cycle %0d instead of cycle %0d",
					cycle_count, exp_cycle));
			end
		end
	end

	initial
	begin : watchdog
		#(RUN_CYCLES * CLK_PERIOD);
		fail_and_stop("Timeout: the run did not finish in the expected number of cycles");
	end

	initial
	begin : stimulus
		rst_n = 1'b1;
		in_valid = 1'b0;
		req = '0;
		// Reset edge well clear of time zero
		#0.5;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
		run_directed();
		run_random();
		in_valid = 1'b0;
		req = '0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (i_simd_alu_top.u_chk.error_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			fail_and_stop("A bound checker assertion failed before the end of the run");
		end
	end

endmodule

// File: sim.f
+incdir+common
common/simd_alu_pkg.sv
source/simd_stage_reg.sv
source/simd_alu_decode.sv
simd_lane_alu/simd_lane_alu.sv
source/simd_shift_unit.sv
source/simd_alu_execute.sv
source/simd_alu_result.sv
source/simd_alu_top.sv
dv/simd_alu_chk.sv
dv/simd_alu_tb.sv

// File: Bender.yml
package:
  name: simd_alu

sources:
  - include_dirs:
      - common
    files:
      - common/simd_alu_pkg.sv
      - source/simd_stage_reg.sv
      - source/simd_alu_decode.sv
      - simd_lane_alu/simd_lane_alu.sv
      - source/simd_shift_unit.sv
      - source/simd_alu_execute.sv
      - source/simd_alu_result.sv
      - source/simd_alu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/simd_alu_chk.sv
      - dv/simd_alu_tb.sv
